//--- bypass_pkg.sv
//--------------------------------------------------------------------------
// Widths and beat types shared by the raw Ethernet bypass stack
// The keep width is derived from the data width, so data_bits must be a
// multiple of 8
//--------------------------------------------------------------------------
package bypass_pkg;

    // Stream bus width and its byte enables
    parameter int data_bits = 64;
    parameter int keep_bits = data_bits / 8;

    // Byte length of one packet
    parameter int len_bits = 16;

    // Host virtual address
    parameter int vaddr_bits = 32;

    // Queue-pair number fields, PID in the low bits and vFID above it
    parameter int pid_bits = 6;
    parameter int vfid_bits = 4;
    parameter int qp_num_bits = pid_bits + vfid_bits;

    // One stream beat as it sits in a data queue
    typedef struct packed {
        logic [data_bits-1:0] data;
        // Byte enables, contiguous from bit zero
        logic [keep_bits-1:0] keep;
        // End of packet
        logic last;
    } beat_t;

    // Measured byte length, payload of the length queue
    typedef logic [len_bits-1:0] len_t;

endpackage

//--- stream_fifo.sv
//--------------------------------------------------------------------------
// Synchronous valid/ready queue with a typed payload
// depth must be at least 2; in_ready is registered, so it is low for
// one cycle after reset; output data shows one cycle after the write
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 16
) (
    input  logic     nclk,
    input  logic     nresetn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    localparam int ptr_bits = $clog2(depth);

    payload_t mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    // One extra bit so a full queue can be told from an empty one
    logic [ptr_bits:0] count;
    logic [ptr_bits:0] count_next;
    logic push;
    logic pop;

    // Pointer step with wrap for any depth
    function automatic logic [ptr_bits-1:0] bump(input logic [ptr_bits-1:0] p);
        return (p == ptr_bits'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_payload = mem[rd_ptr];

    // Occupancy after this cycle, push and pop together keep it
    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count_next;
            // Room left after this cycle
            in_ready <= (count_next < depth);
        end
    end

    // Storage
    always_ff @(posedge nclk) begin
        if (push) begin
            mem[wr_ptr] <= in_payload;
        end
    end

    // Registered ready must never let a beat into a full queue
    assert property (@(posedge nclk) disable iff (!nresetn) push |-> (count < depth))
        else $error("stream_fifo write while full");

endmodule

//--- rx_len_meter.sv
//--------------------------------------------------------------------------
// Byte length meter for received packets
// Byte enables must be contiguous from bit zero; the meter stalls
// receive while a measured length waits for the length queue
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module rx_len_meter (
    input  logic                             nclk,
    input  logic                             nresetn,
    input  logic                             beat_fire,
    input  logic [bypass_pkg::keep_bits-1:0] beat_keep,
    input  logic                             beat_last,
    output logic                             stall,
    output logic                             len_valid,
    input  logic                             len_ready,
    output bypass_pkg::len_t                 len
);

    bypass_pkg::len_t acc;
    bypass_pkg::len_t beat_bytes;

    // Number of enabled bytes in one beat
    function automatic bypass_pkg::len_t popcount(input logic [bypass_pkg::keep_bits-1:0] k);
        bypass_pkg::len_t n;
        n = '0;
        for (int i = 0; i < bypass_pkg::keep_bits; i++) begin
            n = n + k[i];
        end
        return n;
    endfunction

    assign beat_bytes = popcount(beat_keep);

    // Hold receive off until the pending length is taken
    assign stall = len_valid && !len_ready;

    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            acc <= '0;
            len_valid <= 1'b0;
        end else begin
            if (len_valid && len_ready) begin
                len_valid <= 1'b0;
            end
            if (beat_fire) begin
                if (beat_last) begin
                    // Packet done, offer its total next cycle
                    acc <= '0;
                    len_valid <= 1'b1;
                end else begin
                    acc <= acc + beat_bytes;
                end
            end
        end
    end

    // Total includes the last beat
    always_ff @(posedge nclk) begin
        if (beat_fire && beat_last) begin
            len <= acc + beat_bytes;
        end
    end

    // Enables of the form 0..01..1
    assert property (@(posedge nclk) disable iff (!nresetn)
        beat_fire |-> ((beat_keep & (beat_keep + 1'b1)) == '0))
        else $error("rx_len_meter byte enables not contiguous");

endmodule

//--- rx_write_ctrl.sv
//--------------------------------------------------------------------------
// Receive write sequencer into a circular host buffer
// One packet at a time: descriptor first, then its data; the slot offset
// wraps after num_slots slots, and num_slots * slot_bytes must fit 32 bits
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module rx_write_ctrl #(
    parameter int num_slots = 1024,
    parameter int slot_bytes = 4096
) (
    input  logic                               nclk,
    input  logic                               nresetn,
    input  logic                               qp_valid,
    input  logic [bypass_pkg::vaddr_bits-1:0]  qp_vaddr,
    input  logic [bypass_pkg::qp_num_bits-1:0] qp_num,
    input  logic                               len_valid,
    output logic                               len_ready,
    input  bypass_pkg::len_t                   len,
    input  logic                               data_valid,
    output logic                               data_ready,
    input  bypass_pkg::beat_t                  data_beat,
    output logic                               wr_req_valid,
    input  logic                               wr_req_ready,
    output logic [bypass_pkg::vaddr_bits-1:0]  wr_req_vaddr,
    output bypass_pkg::len_t                   wr_req_len,
    output logic [bypass_pkg::pid_bits-1:0]    wr_req_pid,
    output logic [bypass_pkg::vfid_bits-1:0]   wr_req_vfid,
    output logic                               wr_valid,
    input  logic                               wr_ready,
    output bypass_pkg::beat_t                  wr_beat
);

    localparam int unsigned ring_bytes = num_slots * slot_bytes;
    localparam logic [bypass_pkg::vaddr_bits-1:0] slot_step = slot_bytes;
    localparam logic [bypass_pkg::vaddr_bits-1:0] last_offset = ring_bytes - slot_bytes;

    typedef enum logic [1:0] {
        st_wait,
        st_desc,
        st_data
    } state_t;

    state_t state;
    logic [bypass_pkg::vaddr_bits-1:0] base;
    logic [bypass_pkg::vaddr_bits-1:0] offset;
    logic [bypass_pkg::pid_bits-1:0] pid;
    logic [bypass_pkg::vfid_bits-1:0] vfid;
    bypass_pkg::len_t cur_len;
    logic data_fire;

    // Queue-pair context, setup beat is always taken
    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            base <= '0;
            pid <= '0;
            vfid <= '0;
        end else if (qp_valid) begin
            base <= qp_vaddr;
            pid <= qp_num[bypass_pkg::pid_bits-1:0];
            vfid <= qp_num[bypass_pkg::pid_bits +: bypass_pkg::vfid_bits];
        end
    end

    assign data_fire = data_valid && data_ready;

    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            state <= st_wait;
            offset <= '0;
            cur_len <= '0;
        end else begin
            case (state)
                st_wait: begin
                    // Pop one length, a whole packet is queued behind it
                    if (len_valid) begin
                        cur_len <= len;
                        state <= st_desc;
                    end
                end
                st_desc: begin
                    if (wr_req_ready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (data_fire && data_beat.last) begin
                        // Next slot, back to the ring start after the last one
                        offset <= (offset == last_offset) ? '0 : offset + slot_step;
                        state <= st_wait;
                    end
                end
                default: state <= st_wait;
            endcase
        end
    end

    assign len_ready = (state == st_wait);

    // Descriptor
    assign wr_req_valid = (state == st_desc);
    assign wr_req_vaddr = base + offset;
    assign wr_req_len = cur_len;
    assign wr_req_pid = pid;
    assign wr_req_vfid = vfid;

    // Data only moves after the descriptor is taken
    assign wr_valid = data_valid && (state == st_data);
    assign data_ready = wr_ready && (state == st_data);
    assign wr_beat = data_beat;

    assert property (@(posedge nclk) disable iff (!nresetn) offset < ring_bytes)
        else $error("rx_write_ctrl slot offset outside ring");

endmodule

//--- pkt_stats.sv
//--------------------------------------------------------------------------
// Transmit and receive packet counters
// Both wrap at 2**32 and are never cleared except by reset
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module pkt_stats (
    input  logic        nclk,
    input  logic        nresetn,
    input  logic        tx_fire_last,
    input  logic        rx_fire_last,
    output logic [31:0] tx_pkt_count,
    output logic [31:0] rx_pkt_count
);

    // One step per accepted last beat
    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            tx_pkt_count <= '0;
            rx_pkt_count <= '0;
        end else begin
            if (tx_fire_last) begin
                tx_pkt_count <= tx_pkt_count + 1'b1;
            end
            if (rx_fire_last) begin
                rx_pkt_count <= rx_pkt_count + 1'b1;
            end
        end
    end

    // At most one packet ends per cycle and direction
    assert property (@(posedge nclk) disable iff (!nresetn)
        (tx_pkt_count - $past(tx_pkt_count)) <= 32'd1 &&
        (rx_pkt_count - $past(rx_pkt_count)) <= 32'd1)
        else $error("pkt_stats counter stepped by more than one");

endmodule

//--- bypass_stack.sv
//--------------------------------------------------------------------------
// Raw Ethernet bypass stack, receive to host ring and transmit buffering
// A received packet may be at most data_fifo_depth beats long; a longer
// one stalls receive for good and is not detected
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module bypass_stack #(
    parameter int num_slots = 1024,
    parameter int slot_bytes = 4096,
    parameter int data_fifo_depth = 16,
    parameter int len_fifo_depth = 16
) (
    input  logic                               nclk,
    input  logic                               nresetn,
    // Network receive
    input  logic                               rx_valid,
    output logic                               rx_ready,
    input  logic [bypass_pkg::data_bits-1:0]   rx_data,
    input  logic [bypass_pkg::keep_bits-1:0]   rx_keep,
    input  logic                               rx_last,
    // Network transmit
    output logic                               tx_valid,
    input  logic                               tx_ready,
    output logic [bypass_pkg::data_bits-1:0]   tx_data,
    output logic [bypass_pkg::keep_bits-1:0]   tx_keep,
    output logic                               tx_last,
    // Memory read response
    input  logic                               rd_rsp_valid,
    output logic                               rd_rsp_ready,
    input  logic [bypass_pkg::data_bits-1:0]   rd_rsp_data,
    input  logic [bypass_pkg::keep_bits-1:0]   rd_rsp_keep,
    input  logic                               rd_rsp_last,
    // Write descriptor
    output logic                               wr_req_valid,
    input  logic                               wr_req_ready,
    output logic [bypass_pkg::vaddr_bits-1:0]  wr_req_vaddr,
    output bypass_pkg::len_t                   wr_req_len,
    output logic [bypass_pkg::pid_bits-1:0]    wr_req_pid,
    output logic [bypass_pkg::vfid_bits-1:0]   wr_req_vfid,
    // Write data
    output logic                               wr_valid,
    input  logic                               wr_ready,
    output logic [bypass_pkg::data_bits-1:0]   wr_data,
    output logic [bypass_pkg::keep_bits-1:0]   wr_keep,
    output logic                               wr_last,
    // Queue-pair setup
    input  logic                               qp_valid,
    input  logic [bypass_pkg::vaddr_bits-1:0]  qp_vaddr,
    input  logic [bypass_pkg::qp_num_bits-1:0] qp_num,
    // Statistics
    output logic [31:0]                        tx_pkt_count,
    output logic [31:0]                        rx_pkt_count
);

    bypass_pkg::beat_t rd_rsp_beat;
    bypass_pkg::beat_t tx_beat;
    bypass_pkg::beat_t rx_beat;
    bypass_pkg::beat_t rxq_beat;
    bypass_pkg::beat_t wr_beat;
    logic rxq_in_ready;
    logic rxq_valid;
    logic rxq_ready;
    logic meter_stall;
    logic meter_len_valid;
    logic meter_len_ready;
    bypass_pkg::len_t meter_len;
    logic lenq_valid;
    logic lenq_ready;
    bypass_pkg::len_t lenq_len;

    // Transmit side, queue latency only
    assign rd_rsp_beat = '{data: rd_rsp_data, keep: rd_rsp_keep, last: rd_rsp_last};
    assign tx_data = tx_beat.data;
    assign tx_keep = tx_beat.keep;
    assign tx_last = tx_beat.last;

    stream_fifo #(.payload_t(bypass_pkg::beat_t), .depth(data_fifo_depth)) tx_fifo (
        .nclk(nclk), .nresetn(nresetn),
        .in_valid(rd_rsp_valid), .in_ready(rd_rsp_ready), .in_payload(rd_rsp_beat),
        .out_valid(tx_valid), .out_ready(tx_ready), .out_payload(tx_beat)
    );

    // Receive input needs room for the beat and no pending length
    assign rx_beat = '{data: rx_data, keep: rx_keep, last: rx_last};
    assign rx_ready = rxq_in_ready && !meter_stall;

    stream_fifo #(.payload_t(bypass_pkg::beat_t), .depth(data_fifo_depth)) rx_fifo (
        .nclk(nclk), .nresetn(nresetn),
        .in_valid(rx_valid && !meter_stall), .in_ready(rxq_in_ready), .in_payload(rx_beat),
        .out_valid(rxq_valid), .out_ready(rxq_ready), .out_payload(rxq_beat)
    );

    rx_len_meter meter (
        .nclk(nclk), .nresetn(nresetn),
        .beat_fire(rx_valid && rx_ready), .beat_keep(rx_keep), .beat_last(rx_last),
        .stall(meter_stall),
        .len_valid(meter_len_valid), .len_ready(meter_len_ready), .len(meter_len)
    );

    stream_fifo #(.payload_t(bypass_pkg::len_t), .depth(len_fifo_depth)) len_fifo (
        .nclk(nclk), .nresetn(nresetn),
        .in_valid(meter_len_valid), .in_ready(meter_len_ready), .in_payload(meter_len),
        .out_valid(lenq_valid), .out_ready(lenq_ready), .out_payload(lenq_len)
    );

    rx_write_ctrl #(.num_slots(num_slots), .slot_bytes(slot_bytes)) write_ctrl (
        .nclk(nclk), .nresetn(nresetn),
        .qp_valid(qp_valid), .qp_vaddr(qp_vaddr), .qp_num(qp_num),
        .len_valid(lenq_valid), .len_ready(lenq_ready), .len(lenq_len),
        .data_valid(rxq_valid), .data_ready(rxq_ready), .data_beat(rxq_beat),
        .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
        .wr_req_vaddr(wr_req_vaddr), .wr_req_len(wr_req_len),
        .wr_req_pid(wr_req_pid), .wr_req_vfid(wr_req_vfid),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_beat(wr_beat)
    );

    assign wr_data = wr_beat.data;
    assign wr_keep = wr_beat.keep;
    assign wr_last = wr_beat.last;

    // Packets counted where they leave the stack
    pkt_stats stats (
        .nclk(nclk), .nresetn(nresetn),
        .tx_fire_last(tx_valid && tx_ready && tx_last),
        .rx_fire_last(wr_valid && wr_ready && wr_last),
        .tx_pkt_count(tx_pkt_count), .rx_pkt_count(rx_pkt_count)
    );

endmodule

//--- tb_bypass_stack.sv
//--------------------------------------------------------------------------
// Directed testbench for the bypass stack with a ring of 4 slots of 4096 bytes
// Packets stay at 5 beats or fewer to fit well inside the receive queue depth
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_bypass_stack;

    localparam int num_slots = 4;
    localparam int slot_bytes = 4096;
    localparam int max_beats = 5;

    logic nclk;
    logic nresetn;
    logic rx_valid;
    logic rx_ready;
    logic rx_last;
    logic [bypass_pkg::data_bits-1:0] rx_data;
    logic [bypass_pkg::keep_bits-1:0] rx_keep;
    logic tx_valid;
    logic tx_ready;
    logic tx_last;
    logic [bypass_pkg::data_bits-1:0] tx_data;
    logic [bypass_pkg::keep_bits-1:0] tx_keep;
    logic rd_rsp_valid;
    logic rd_rsp_ready;
    logic rd_rsp_last;
    logic [bypass_pkg::data_bits-1:0] rd_rsp_data;
    logic [bypass_pkg::keep_bits-1:0] rd_rsp_keep;
    logic wr_req_valid;
    logic wr_req_ready;
    logic [bypass_pkg::vaddr_bits-1:0] wr_req_vaddr;
    bypass_pkg::len_t wr_req_len;
    logic [bypass_pkg::pid_bits-1:0] wr_req_pid;
    logic [bypass_pkg::vfid_bits-1:0] wr_req_vfid;
    logic wr_valid;
    logic wr_ready;
    logic wr_last;
    logic [bypass_pkg::data_bits-1:0] wr_data;
    logic [bypass_pkg::keep_bits-1:0] wr_keep;
    logic qp_valid;
    logic [bypass_pkg::vaddr_bits-1:0] qp_vaddr;
    logic [bypass_pkg::qp_num_bits-1:0] qp_num;
    logic [31:0] tx_pkt_count;
    logic [31:0] rx_pkt_count;

    logic [31:0] seed = 32'he7df_f7bb;
    // Queues of beats to drive, beats expected out and descriptors as {vaddr, len}
    bypass_pkg::beat_t stim_q[$];
    bypass_pkg::beat_t exp_q[$];
    logic [47:0] desc_q[$];
    // Context from the last setup beat and the next ring slot
    logic [bypass_pkg::vaddr_bits-1:0] cur_base;
    logic [bypass_pkg::qp_num_bits-1:0] cur_qpn;
    int slot;
    // Transmit packets sent since the last reset
    int tx_sent;

    bypass_stack #(.num_slots(num_slots), .slot_bytes(slot_bytes)) UUT (
        .nclk(nclk), .nresetn(nresetn),
        .rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(rx_data),
        .rx_keep(rx_keep), .rx_last(rx_last),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data),
        .tx_keep(tx_keep), .tx_last(tx_last),
        .rd_rsp_valid(rd_rsp_valid), .rd_rsp_ready(rd_rsp_ready), .rd_rsp_data(rd_rsp_data),
        .rd_rsp_keep(rd_rsp_keep), .rd_rsp_last(rd_rsp_last),
        .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
        .wr_req_vaddr(wr_req_vaddr), .wr_req_len(wr_req_len),
        .wr_req_pid(wr_req_pid), .wr_req_vfid(wr_req_vfid),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .wr_keep(wr_keep), .wr_last(wr_last),
        .qp_valid(qp_valid), .qp_vaddr(qp_vaddr), .qp_num(qp_num),
        .tx_pkt_count(tx_pkt_count), .rx_pkt_count(rx_pkt_count)
    );

    // 20 ns period
    always #10 nclk = ~nclk;

    // LCG step with the better bits at the top
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[16];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic apply_reset();
        nresetn <= 1'b0;
        repeat (4) @(posedge nclk);
        nresetn <= 1'b1;
        slot = 0;
        tx_sent = 0;
        @(posedge nclk);
    endtask

    // Setup beat is taken on the next edge without a ready
    task automatic send_setup(input logic [31:0] base, input logic [9:0] qpn);
        qp_valid <= 1'b1;
        qp_vaddr <= base;
        qp_num <= qpn;
        @(posedge nclk);
        qp_valid <= 1'b0;
        cur_base = base;
        cur_qpn = qpn;
    endtask

    // Random packets of full beats and a last beat of 1..8 bytes
    task automatic make_packets(input int npkt, input bit for_rx);
        bypass_pkg::beat_t b;
        int nb;
        int tail;
        int bytes;
        for (int p = 0; p < npkt; p++) begin
            nb = 1 + int'((next_rand() >> 16) % max_beats);
            bytes = 0;
            for (int i = 0; i < nb; i++) begin
                b.data = {next_rand(), next_rand()};
                b.last = (i == nb - 1);
                tail = b.last ? 1 + int'((next_rand() >> 16) % bypass_pkg::keep_bits) : 8;
                b.keep = {bypass_pkg::keep_bits{1'b1}} >> (bypass_pkg::keep_bits - tail);
                bytes += tail;
                stim_q.push_back(b);
                exp_q.push_back(b);
            end
            // Receive slot address is base plus slot index times the stride
            if (for_rx) begin
                desc_q.push_back({32'(cur_base + slot * slot_bytes), 16'(bytes)});
                slot = (slot + 1) % num_slots;
            end else begin
                tx_sent++;
            end
        end
    endtask

    task automatic drive_rx();
        bypass_pkg::beat_t b;
        int waited;
        while (stim_q.size() > 0) begin
            b = stim_q.pop_front();
            rx_valid <= 1'b1;
            rx_data <= b.data;
            rx_keep <= b.keep;
            rx_last <= b.last;
            waited = 0;
            do begin
                @(posedge nclk);
                waited++;
                if (waited > 500) abort_run("rx_ready stayed low, receive input stuck");
            end while (!rx_ready);
        end
        rx_valid <= 1'b0;
    endtask

    task automatic drive_rd_rsp();
        bypass_pkg::beat_t b;
        int waited;
        while (stim_q.size() > 0) begin
            b = stim_q.pop_front();
            rd_rsp_valid <= 1'b1;
            rd_rsp_data <= b.data;
            rd_rsp_keep <= b.keep;
            rd_rsp_last <= b.last;
            waited = 0;
            do begin
                @(posedge nclk);
                waited++;
                if (waited > 500) abort_run("rd_rsp_ready stayed low, transmit input stuck");
            end while (!rd_rsp_ready);
        end
        rd_rsp_valid <= 1'b0;
    endtask

    // Descriptors and data arrive in order with data only after its own descriptor
    task automatic collect_rx(input bit rand_ready);
        bypass_pkg::beat_t e;
        logic [47:0] d;
        int descs;
        int done;
        int waited;
        logic desc_seen;
        descs = 0;
        done = 0;
        waited = 0;
        while (exp_q.size() > 0 || desc_q.size() > 0) begin
            wr_req_ready <= rand_ready ? rand_bit() : 1'b1;
            wr_ready <= rand_ready ? rand_bit() : 1'b1;
            @(posedge nclk);
            desc_seen = (descs > done);
            if (wr_req_valid && wr_req_ready) begin
                if (desc_q.size() == 0) abort_run("write descriptor with no packet pending");
                d = desc_q.pop_front();
                check_value("wr_req_vaddr", wr_req_vaddr, d[47:16]);
                check_value("wr_req_len", wr_req_len, d[15:0]);
                check_value("wr_req_pid", wr_req_pid, cur_qpn[bypass_pkg::pid_bits-1:0]);
                check_value("wr_req_vfid", wr_req_vfid,
                            cur_qpn[bypass_pkg::pid_bits +: bypass_pkg::vfid_bits]);
                descs++;
            end
            if (wr_valid && wr_ready) begin
                if (exp_q.size() == 0) abort_run("write data beat that was never sent");
                e = exp_q.pop_front();
                check_value("desc_before_data", desc_seen, 1'b1);
                check_value("wr_data", wr_data, e.data);
                check_value("wr_keep", wr_keep, e.keep);
                check_value("wr_last", wr_last, e.last);
                if (wr_last) done++;
            end
            waited++;
            if (waited > 2000) abort_run("receive packets did not all reach the write port");
        end
        wr_req_ready <= 1'b0;
        wr_ready <= 1'b0;
    endtask

    task automatic collect_tx();
        bypass_pkg::beat_t e;
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            tx_ready <= rand_bit();
            @(posedge nclk);
            if (tx_valid && tx_ready) begin
                e = exp_q.pop_front();
                check_value("tx_data", tx_data, e.data);
                check_value("tx_keep", tx_keep, e.keep);
                check_value("tx_last", tx_last, e.last);
            end
            waited++;
            if (waited > 2000) abort_run("transmit packets did not all reach the network port");
        end
        tx_ready <= 1'b0;
    endtask

    task automatic check_reset_state();
        apply_reset();
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("wr_req_valid", wr_req_valid, 1'b0);
        check_value("wr_valid", wr_valid, 1'b0);
        check_value("tx_pkt_count", tx_pkt_count, 0);
        check_value("rx_pkt_count", rx_pkt_count, 0);
    endtask

    task automatic single_packet();
        send_setup(next_rand(), next_rand() >> 16);
        make_packets(1, 1'b1);
        fork
            drive_rx();
            collect_rx(1'b0);
        join
    endtask

    // Fresh ring so the six slots go 0, 1, 2, 3, 0, 1
    task automatic slot_wrap();
        apply_reset();
        send_setup(next_rand(), next_rand() >> 16);
        make_packets(6, 1'b1);
        fork
            drive_rx();
            collect_rx(1'b0);
        join
        @(posedge nclk);
        check_value("rx_pkt_count", rx_pkt_count, 6);
    endtask

    task automatic random_backpressure();
        send_setup(next_rand(), next_rand() >> 16);
        make_packets(8, 1'b1);
        fork
            drive_rx();
            collect_rx(1'b1);
        join
    endtask

    task automatic transmit_path();
        make_packets(6, 1'b0);
        fork
            drive_rd_rsp();
            collect_tx();
        join
        @(posedge nclk);
        check_value("tx_pkt_count", tx_pkt_count, tx_sent);
    endtask

    initial begin
        nclk = 1'b0;
        nresetn = 1'b0;
        rx_valid = 1'b0;
        rx_data = '0;
        rx_keep = '0;
        rx_last = 1'b0;
        tx_ready = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_data = '0;
        rd_rsp_keep = '0;
        rd_rsp_last = 1'b0;
        wr_req_ready = 1'b0;
        wr_ready = 1'b0;
        qp_valid = 1'b0;
        qp_vaddr = '0;
        qp_num = '0;
        slot = 0;
        tx_sent = 0;
        check_reset_state();
        single_packet();
        slot_wrap();
        random_backpressure();
        transmit_path();
        $display("No errors");
        $finish;
    end

endmodule

//--- flist.f
bypass_pkg.sv
stream_fifo.sv
rx_len_meter.sv
rx_write_ctrl.sv
pkt_stats.sv
bypass_stack.sv
tb_bypass_stack.sv
